/* rtl/nocPkg.sv */
`default_nettype none

package nocPkg;

  // router geometry.
  localparam int numPorts = 5;

  // port index, also used as the grant number.
  typedef logic [2:0] portSelT;

  // rotation order is L, N, E, W, S.
  localparam portSelT portL = 3'd0;
  localparam portSelT portN = 3'd1;
  localparam portSelT portE = 3'd2;
  localparam portSelT portW = 3'd3;
  localparam portSelT portS = 3'd4;

  // flit field widths.
  localparam int lengthW = 12;
  localparam int dataW = 16;

  // flit kind codes.
  typedef logic [2:0] flitIdT;

  localparam flitIdT flitHead = 3'd1;
  localparam flitIdT flitBody = 3'd2;
  localparam flitIdT flitTail = 3'd3;

  // one flit as it moves through the queues and onto the link.
  typedef struct packed {
    flitIdT flitId;
    logic [lengthW-1:0] length; // grant limit, in flits, for a header.
    logic [dataW-1:0] data;
  } flitT;

endpackage

`default_nettype wire

/* rtl/inputQueue.sv */
`timescale 1ns/10ps
`default_nettype none

module inputQueue #(
  parameter int queueDepth = 8
) (
  input logic clk,
  input logic rst,
  input logic push,
  input nocPkg::flitT pushFlit,
  input logic pop,
  output nocPkg::flitT headFlit,
  output logic notEmpty,
  output logic overflow
);

  localparam int ptrW = $clog2(queueDepth);

  nocPkg::flitT mem [queueDepth];

  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [ptrW:0] count;
  logic full;
  logic pushOk;
  logic popOk;

  assign full = (count == queueDepth[ptrW:0]);
  assign notEmpty = (count != '0);

  // a push on a full queue still fits when the head leaves in the same cycle.
  assign pushOk = push && (!full || pop);
  assign popOk = pop && notEmpty;

  assign headFlit = mem[rdPtr]; // head seen without a pop.

  always_ff @(posedge clk)
  begin
    if (pushOk)
    begin
      mem[wrPtr] <= pushFlit;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
      overflow <= 1'b0;
    end
    else
    begin
      if (pushOk)
      begin
        wrPtr <= wrPtr + 1'b1; // depth is a power of two, wraps by itself.
      end
      if (popOk)
      begin
        rdPtr <= rdPtr + 1'b1;
      end
      if (pushOk && !popOk)
      begin
        count <= count + 1'b1;
      end
      else if (popOk && !pushOk)
      begin
        count <= count - 1'b1;
      end
      if (push && !pushOk)
      begin
        overflow <= 1'b1; // dropped flit, held until reset.
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/portTimer.sv */
`timescale 1ns/10ps
`default_nettype none

module portTimer (
  input logic clk,
  input logic rst,
  input nocPkg::flitT headFlit,
  input logic runTimer,
  output logic timesUp
);

  logic [nocPkg::lengthW-1:0] limit;
  logic [nocPkg::lengthW-1:0] count;
  logic loadLimit;

  // a waiting header sets the length of the next grant.
  assign loadLimit = !runTimer && (headFlit.flitId == nocPkg::flitHead);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (loadLimit)
      begin
        limit <= headFlit.length;
      end
      if (runTimer)
      begin
        count <= count + 1'b1; // one per popped flit.
      end
      else
      begin
        count <= '0;
      end
    end
  end

  assign timesUp = (count == limit);

endmodule

`default_nettype wire

/* rtl/outputArbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module outputArbiter (
  input logic clk,
  input logic rst,
  input logic [nocPkg::numPorts-1:0] notEmpty,
  input logic [nocPkg::numPorts-1:0] timesUp,
  output logic [nocPkg::numPorts-1:0] pop,
  output logic [nocPkg::numPorts-1:0] runTimer
);

  // bit 0 is idle, bit p+1 is the grant of port p.
  typedef logic [nocPkg::numPorts:0] stateT;

  localparam stateT idleState = stateT'(1);

  stateT state;
  stateT nextState;

  // first requesting port at or after startPort, in cyclic order.
  function automatic stateT nextGrant(
    input logic [nocPkg::numPorts-1:0] req,
    input int startPort
  );
    stateT grant;
    int idx;
    grant = idleState;
    // walk backwards so the nearest requester is written last.
    for (int k = nocPkg::numPorts - 1; k >= 0; k--)
    begin
      idx = (startPort + k) % nocPkg::numPorts;
      if (req[idx])
      begin
        grant = '0;
        grant[idx + 1] = 1'b1;
      end
    end
    return grant;
  endfunction

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= idleState;
    end
    else
    begin
      state <= nextState;
    end
  end

  always_comb
  begin
    nextState = state;
    pop = '0;
    runTimer = '0;

    if (state[0])
    begin
      nextState = nextGrant(notEmpty, nocPkg::portL); // fixed order from idle.
    end

    for (int p = 0; p < nocPkg::numPorts; p++)
    begin
      if (state[p + 1])
      begin
        if (notEmpty[p] && !timesUp[p])
        begin
          pop[p] = 1'b1; // keep the link and send one flit.
          runTimer[p] = 1'b1;
        end
        else
        begin
          // hand over, this port comes last in the search.
          nextState = nextGrant(notEmpty, (p + 1) % nocPkg::numPorts);
        end
      end
    end

    if (!$onehot(state))
    begin
      nextState = idleState; // recover from a broken state code.
    end
  end

endmodule

`default_nettype wire

/* rtl/outputSwitch.sv */
`timescale 1ns/10ps
`default_nettype none

module outputSwitch (
  input logic clk,
  input logic rst,
  input nocPkg::flitT [nocPkg::numPorts-1:0] headFlit,
  input logic [nocPkg::numPorts-1:0] pop,
  output logic outValid,
  output nocPkg::flitT outFlit,
  output nocPkg::portSelT outPort
);

  nocPkg::portSelT sel;
  logic anyPop;

  assign anyPop = |pop;

  // one-hot pop to port index.
  always_comb
  begin
    sel = nocPkg::portL;
    for (int p = 0; p < nocPkg::numPorts; p++)
    begin
      if (pop[p])
      begin
        sel = nocPkg::portSelT'(p);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
    end
    else
    begin
      outValid <= anyPop; // strobe follows the pop by one cycle.
    end
  end

  always_ff @(posedge clk)
  begin
    if (anyPop)
    begin
      outFlit <= headFlit[sel];
      outPort <= sel;
    end
  end

endmodule

`default_nettype wire

/* rtl/routerOutputTop.sv */
`timescale 1ns/10ps
`default_nettype none

module routerOutputTop #(
  parameter int queueDepth = 8
) (
  input logic clk,
  input logic rst,
  input logic [nocPkg::numPorts-1:0] inValid,
  input nocPkg::flitT [nocPkg::numPorts-1:0] inFlit,
  output logic outValid,
  output nocPkg::flitT outFlit,
  output nocPkg::portSelT outPort,
  output logic [nocPkg::numPorts-1:0] overflow
);

  logic [nocPkg::numPorts-1:0] notEmpty;
  logic [nocPkg::numPorts-1:0] timesUp;
  logic [nocPkg::numPorts-1:0] pop;
  logic [nocPkg::numPorts-1:0] runTimer;
  nocPkg::flitT [nocPkg::numPorts-1:0] headFlit;

  // one queue and one grant timer per input port.
  for (genvar p = 0; p < nocPkg::numPorts; p++)
  begin : portGen
    inputQueue #(
      .queueDepth(queueDepth)
    ) inQueue (
      .clk(clk),
      .rst(rst),
      .push(inValid[p]),
      .pushFlit(inFlit[p]),
      .pop(pop[p]),
      .headFlit(headFlit[p]),
      .notEmpty(notEmpty[p]),
      .overflow(overflow[p])
    );

    portTimer grantTimer (
      .clk(clk),
      .rst(rst),
      .headFlit(headFlit[p]),
      .runTimer(runTimer[p]),
      .timesUp(timesUp[p])
    );
  end

  outputArbiter arbiter (
    .clk(clk),
    .rst(rst),
    .notEmpty(notEmpty),
    .timesUp(timesUp),
    .pop(pop),
    .runTimer(runTimer)
  );

  outputSwitch switchOut (
    .clk(clk),
    .rst(rst),
    .headFlit(headFlit),
    .pop(pop),
    .outValid(outValid),
    .outFlit(outFlit),
    .outPort(outPort)
  );

endmodule

`default_nettype wire

/* testbench/clockGen.sv */
`timescale 1ns/10ps
`default_nettype none

module clockGen #(
  parameter int halfPeriod = 50,
  parameter int resetCycles = 3
) (
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #(halfPeriod) clk = ~clk; // 100 ns period.
    end
  end

  initial
  begin
    rst = 1'b1;
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0; // released away from the active edge.
  end

endmodule

`default_nettype wire

/* testbench/routerOutputTb.sv */
`timescale 1ns/10ps
`default_nettype none

module routerOutputTb;

  localparam int queueDepth = 8;
  localparam int numPkts = 12;
  localparam int lastScen = 6;
  localparam int flitTimeout = 64; // cycles allowed before each output flit.
  localparam int quietCycles = 12;

  // one packet of the stimulus table.
  typedef struct packed {
    int scen;
    nocPkg::portSelT port;
    int numFlits;
    logic [nocPkg::lengthW-1:0] hdrLen;
  } pktRowT;

  // one flit strobe at a beat of its scenario.
  typedef struct packed {
    int scen;
    int beat;
    nocPkg::portSelT port;
    nocPkg::flitT flit;
  } stimRowT;

  typedef struct packed {
    nocPkg::portSelT port;
    nocPkg::flitT flit;
  } expRowT;

  // 2 single packet, 3 contention, 4 all ports, 5 overflow on E, 6 after drain.
  pktRowT pktTable [numPkts] = '{
    '{2, nocPkg::portN, 3, 12'd3},
    '{3, nocPkg::portN, 4, 12'd2},
    '{3, nocPkg::portW, 3, 12'd3},
    '{4, nocPkg::portL, 2, 12'd2},
    '{4, nocPkg::portN, 3, 12'd3},
    '{4, nocPkg::portE, 2, 12'd2},
    '{4, nocPkg::portW, 3, 12'd3},
    '{4, nocPkg::portS, 2, 12'd2},
    '{5, nocPkg::portL, 8, 12'd8},
    '{5, nocPkg::portE, 9, 12'd9},
    '{6, nocPkg::portS, 2, 12'd2},
    '{6, nocPkg::portN, 3, 12'd3}
  };

  logic clk;
  logic rst;
  logic [nocPkg::numPorts-1:0] inValid;
  nocPkg::flitT [nocPkg::numPorts-1:0] inFlit;
  logic outValid;
  nocPkg::flitT outFlit;
  nocPkg::portSelT outPort;
  logic [nocPkg::numPorts-1:0] overflow;

  stimRowT stimQ [$];
  expRowT expQ [$];
  logic [7:0] lfsrState = 8'd54;
  logic [nocPkg::lengthW-1:0] lastLimit [nocPkg::numPorts]; // model copy of each timer limit.
  logic [nocPkg::numPorts-1:0] expFlags;

  clockGen clkGen (
    .clk(clk),
    .rst(rst)
  );

  routerOutputTop #(
    .queueDepth(queueDepth)
  ) UUT (
    .clk(clk),
    .rst(rst),
    .inValid(inValid),
    .inFlit(inFlit),
    .outValid(outValid),
    .outFlit(outFlit),
    .outPort(outPort),
    .overflow(overflow)
  );

  function automatic logic [7:0] lfsrStep(input logic [7:0] s);
    logic fb;
    fb = s[7] ^ s[5] ^ s[4] ^ s[3]; // x^8 + x^6 + x^5 + x^4 + 1.
    return {s[6:0], fb};
  endfunction

  function automatic logic [nocPkg::dataW-1:0] nextData();
    logic [nocPkg::dataW-1:0] d;
    d = '0;
    for (int i = 0; i < nocPkg::dataW; i++)
    begin
      lfsrState = lfsrStep(lfsrState);
      d = {d[nocPkg::dataW-2:0], lfsrState[7]}; // one step per bit.
    end
    return d;
  endfunction

  function automatic int firstRequester(input logic [nocPkg::numPorts-1:0] req, input int start);
    int found;
    int idx;
    found = -1;
    for (int k = 0; k < nocPkg::numPorts; k++)
    begin
      idx = (start + k) % nocPkg::numPorts;
      if (req[idx] && found < 0)
      begin
        found = idx;
      end
    end
    return found;
  endfunction

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic checkFlit(input nocPkg::flitT got, input nocPkg::flitT exp, input string name);
    if (got !== exp)
    begin
      abortRun($sformatf("FAIL at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic checkPort(input nocPkg::portSelT got, input nocPkg::portSelT exp,
                           input string name);
    if (got !== exp)
    begin
      abortRun($sformatf("FAIL at %0t: %s is %0d, expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic checkFlags(input logic [nocPkg::numPorts-1:0] got,
                            input logic [nocPkg::numPorts-1:0] exp, input string name);
    if (got !== exp)
    begin
      abortRun($sformatf("FAIL at %0t: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  task automatic checkStrobe(input logic got, input logic exp, input string name);
    if (got !== exp)
    begin
      abortRun($sformatf("FAIL at %0t: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  // expands the packet table into flit strobes with each port starting at beat 0.
  task automatic buildStimulus();
    int beatOf [nocPkg::numPorts];
    int prevScen;
    stimRowT row;
    prevScen = -1;
    for (int k = 0; k < numPkts; k++)
    begin
      if (pktTable[k].scen != prevScen)
      begin
        for (int p = 0; p < nocPkg::numPorts; p++)
        begin
          beatOf[p] = 0;
        end
        prevScen = pktTable[k].scen;
      end
      for (int f = 0; f < pktTable[k].numFlits; f++)
      begin
        row.scen = pktTable[k].scen;
        row.port = pktTable[k].port;
        row.beat = beatOf[row.port];
        if (f == 0)
        begin
          row.flit.flitId = nocPkg::flitHead;
          row.flit.length = pktTable[k].hdrLen;
        end
        else
        begin
          row.flit.flitId = (f == pktTable[k].numFlits - 1) ? nocPkg::flitTail : nocPkg::flitBody;
          row.flit.length = '0;
        end
        row.flit.data = nextData();
        stimQ.push_back(row);
        beatOf[row.port]++;
      end
    end
  endtask

  // replays rotation and grant limits over the queue contents of one scenario.
  task automatic buildExpected(input int scen);
    nocPkg::flitT held [nocPkg::numPorts][queueDepth];
    int rdIdx [nocPkg::numPorts];
    int fill [nocPkg::numPorts];
    logic [nocPkg::numPorts-1:0] req;
    int cur;
    int startPort;
    int sent;
    int guard;
    expRowT row;
    expQ.delete();
    for (int p = 0; p < nocPkg::numPorts; p++)
    begin
      rdIdx[p] = 0;
      fill[p] = 0;
    end
    foreach (stimQ[i])
    begin
      if (stimQ[i].scen == scen && fill[stimQ[i].port] < queueDepth)
      begin
        held[stimQ[i].port][fill[stimQ[i].port]] = stimQ[i].flit;
        fill[stimQ[i].port]++;
      end
      else if (stimQ[i].scen == scen)
      begin
        expFlags[stimQ[i].port] = 1'b1; // dropped at a full queue.
      end
    end
    startPort = 0; // idle searches from L.
    guard = 0;
    do
    begin
      for (int p = 0; p < nocPkg::numPorts; p++)
      begin
        req[p] = (rdIdx[p] < fill[p]);
      end
      cur = firstRequester(req, startPort);
      if (cur >= 0)
      begin
        if (held[cur][rdIdx[cur]].flitId == nocPkg::flitHead)
        begin
          lastLimit[cur] = held[cur][rdIdx[cur]].length;
        end
        sent = 0;
        while (rdIdx[cur] < fill[cur] && sent < lastLimit[cur])
        begin
          row.port = nocPkg::portSelT'(cur);
          row.flit = held[cur][rdIdx[cur]];
          expQ.push_back(row);
          rdIdx[cur]++;
          sent++;
        end
        startPort = (cur + 1) % nocPkg::numPorts;
      end
      guard++;
    end
    while (cur >= 0 && guard < 100);
    if (cur >= 0)
    begin
      abortRun("reference model made no progress over the queued flits");
    end
  endtask

  task automatic applyStimulus(input int scen);
    int nBeats;
    nBeats = 0;
    foreach (stimQ[i])
    begin
      if (stimQ[i].scen == scen && stimQ[i].beat >= nBeats)
      begin
        nBeats = stimQ[i].beat + 1;
      end
    end
    for (int b = 0; b < nBeats; b++)
    begin
      @(negedge clk);
      inValid = '0;
      foreach (stimQ[i])
      begin
        if (stimQ[i].scen == scen && stimQ[i].beat == b)
        begin
          inValid[stimQ[i].port] = 1'b1;
          inFlit[stimQ[i].port] = stimQ[i].flit;
        end
      end
    end
    @(negedge clk);
    inValid = '0;
  endtask

  task automatic collectOutput();
    int waited;
    foreach (expQ[i])
    begin
      waited = 0;
      do
      begin
        @(negedge clk);
        waited++;
      end
      while (!outValid && waited < flitTimeout);
      if (!outValid)
      begin
        abortRun($sformatf("timeout waiting for output flit %0d of %0d", i + 1, expQ.size()));
      end
      else
      begin
        checkPort(outPort, expQ[i].port, "outPort");
        checkFlit(outFlit, expQ[i].flit, "outFlit");
      end
    end
  endtask

  task automatic checkQuiet(input int cycles);
    for (int c = 0; c < cycles; c++)
    begin
      @(negedge clk);
      checkStrobe(outValid, 1'b0, "outValid");
    end
    checkFlags(overflow, expFlags, "overflow");
  endtask

  task automatic waitForReset();
    int waited;
    waited = 0;
    do
    begin
      @(posedge clk); // rst only changes on a falling edge.
      waited++;
    end
    while (rst && waited < 20);
    if (rst)
    begin
      abortRun("timeout waiting for reset to be released");
    end
  endtask

  task automatic runScenario(input int scen);
    buildExpected(scen);
    fork
      applyStimulus(scen);
      collectOutput();
    join
    checkQuiet(quietCycles); // link idle again once the queues drain.
  endtask

  initial
  begin
    inValid = '0;
    inFlit = '0;
    expFlags = '0;
    for (int p = 0; p < nocPkg::numPorts; p++)
    begin
      lastLimit[p] = '0;
    end
    buildStimulus();
    waitForReset();
    checkQuiet(20);
    for (int s = 2; s <= lastScen; s++)
    begin
      runScenario(s);
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
rtl/nocPkg.sv
rtl/inputQueue.sv
rtl/portTimer.sv
rtl/outputArbiter.sv
rtl/outputSwitch.sv
rtl/routerOutputTop.sv
testbench/clockGen.sv
testbench/routerOutputTb.sv

/* runSim.sh */
#!/usr/bin/env bash
# Builds the router output stage testbench with Verilator and runs it.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "cannot enter the project directory"
  exit 1
fi

topModule=routerOutputTb
simExe=simRouter
logFile=sim.log

command -v verilator > /dev/null
if [ $? -ne 0 ]; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing -Wno-fatal --top-module "$topModule" -f flist.f -o "$simExe"
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/"$simExe" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

grep -q "Result: PASSED" "$logFile"
if [ $? -ne 0 ]; then
  echo "pass message not found in $logFile"
  exit 1
fi

exit 0
